// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/alu.sv
      - design/reg_file.sv
      - design/ctrl_unit.sv
      - design/cpu_core.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/cpu_core_tb.sv

// File: cpu_core.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/reg_file.sv
design/ctrl_unit.sv
design/cpu_core.sv
verification/cpu_core_tb.sv

// File: design/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
   input  wire cpu_pkg::opcode_e op,
   input  wire cpu_pkg::word_t   a,
   input  wire cpu_pkg::word_t   b,
   output cpu_pkg::word_t        result
);

   logic [3:0] shamt;

   assign shamt = b[3:0];                       // Shift range 0..15.

   always_comb begin
      case (op)
         cpu_pkg::OP_ADD: begin
            result = a + b;                     // Wraps mod 2^16.
         end
         cpu_pkg::OP_SUB: begin
            result = a - b;
         end
         cpu_pkg::OP_AND: begin
            result = a & b;
         end
         cpu_pkg::OP_OR: begin
            result = a | b;
         end
         cpu_pkg::OP_XOR: begin
            result = a ^ b;
         end
         cpu_pkg::OP_SHL: begin
            result = a << shamt;
         end
         cpu_pkg::OP_SHR: begin
            result = a >> shamt;                // Logical, zero fill.
         end
         default: begin
            result = a;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ##########################################################################
// Core dimensions
// ##########################################################################

// Data, address and instruction width.
`define CPU_WIDTH 16

`define CPU_NREGS 16

// ##########################################################################
// Special registers
// ##########################################################################

`define CPU_PC_IDX 15
`define CPU_LINK_IDX 14

// First fetch address.
`define CPU_RESET_PC 16'h0000

`endif

// File: design/cpu_core.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
   input  wire                 clk,
   input  wire                 arst_n,
   input  wire cpu_pkg::word_t mem_rdata,
   output cpu_pkg::word_t      mem_addr,
   output cpu_pkg::word_t      mem_wdata,
   output logic                mem_rd,
   output logic                mem_wr,
   output logic                halted
);

   cpu_pkg::rf_cmd_t rf_cmd;
   cpu_pkg::opcode_e alu_op;
   cpu_pkg::word_t   da;
   cpu_pkg::word_t   db;
   cpu_pkg::word_t   dd;
   cpu_pkg::word_t   pc;
   cpu_pkg::word_t   alu_result;

   ctrl_unit i_ctrl_unit (
      .clk        (clk),
      .arst_n     (arst_n),
      .mem_rdata  (mem_rdata),
      .da         (da),
      .dd         (dd),
      .alu_result (alu_result),
      .pc         (pc),
      .cmd        (rf_cmd),
      .alu_op     (alu_op),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_rd     (mem_rd),
      .mem_wr     (mem_wr),
      .halted     (halted)
   );

   reg_file i_reg_file (
      .clk    (clk),
      .arst_n (arst_n),
      .cmd    (rf_cmd),
      .da     (da),
      .db     (db),
      .dd     (dd),
      .pc     (pc)
   );

   alu i_alu (
      .op     (alu_op),
      .a      (da),
      .b      (db),
      .result (alu_result)
   );

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

   typedef logic [`CPU_WIDTH-1:0] word_t;
   typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;

   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_XOR  = 4'h4,
      OP_SHL  = 4'h5,
      OP_SHR  = 4'h6,
      OP_LDI  = 4'h7,       // Imm8 in ra:rb.
      OP_LD   = 4'h8,
      OP_LDP  = 4'h9,       // Load, then ra += 1.
      OP_ST   = 4'ha,
      OP_JMP  = 4'hb,
      OP_BZ   = 4'hc,       // Branch to ra if rd == 0.
      OP_CALL = 4'hd,
      OP_HALT = 4'he,
      OP_NOP  = 4'hf
   } opcode_e;

   typedef enum logic [2:0] {
      ST_FETCH,
      ST_DECODE,
      ST_EXEC,
      ST_WB,
      ST_HALTED
   } ctrl_state_e;

   typedef struct packed {
      opcode_e  op;
      reg_idx_t rd;
      reg_idx_t ra;
      reg_idx_t rb;
   } instr_t;

   typedef struct packed {
      reg_idx_t sel_a;
      reg_idx_t sel_b;
      reg_idx_t sel_d;
      logic     wb_en;      // Port 1.
      reg_idx_t wb_idx;
      word_t    wb_data;
      logic     chg_en;     // Port 2, always targets sel_a.
      word_t    chg_data;
      logic     inc_pc;
      logic     link;
   } rf_cmd_t;

endpackage

`default_nettype wire

// File: design/ctrl_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module ctrl_unit (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire cpu_pkg::word_t   mem_rdata,
   input  wire cpu_pkg::word_t   da,
   input  wire cpu_pkg::word_t   dd,
   input  wire cpu_pkg::word_t   alu_result,
   input  wire cpu_pkg::word_t   pc,
   output cpu_pkg::rf_cmd_t      cmd,
   output cpu_pkg::opcode_e      alu_op,
   output cpu_pkg::word_t        mem_addr,
   output cpu_pkg::word_t        mem_wdata,
   output logic                  mem_rd,
   output logic                  mem_wr,
   output logic                  halted
);

   cpu_pkg::ctrl_state_e state;
   cpu_pkg::ctrl_state_e state_nxt;
   cpu_pkg::instr_t      ir;
   cpu_pkg::word_t       imm8;
   logic                 running;
   logic                 is_alu;
   logic                 is_load;
   logic                 bz_taken;

   // ##########################################################################
   // State and instruction register
   // ##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= cpu_pkg::ST_FETCH;
         ir      <= '0;
         running <= 1'b0;
      end else begin
         running <= 1'b1;                       // One idle cycle out of reset.
         if (running) begin
            state <= state_nxt;
         end
         if (state == cpu_pkg::ST_DECODE) begin
            ir <= cpu_pkg::instr_t'(mem_rdata);
         end
      end
   end

   // ##########################################################################
   // Decode
   // ##########################################################################

   assign is_alu   = (ir.op inside {cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
                                    cpu_pkg::OP_OR, cpu_pkg::OP_XOR, cpu_pkg::OP_SHL,
                                    cpu_pkg::OP_SHR});
   assign is_load  = (ir.op == cpu_pkg::OP_LD) || (ir.op == cpu_pkg::OP_LDP);
   assign bz_taken = (dd == '0);
   assign imm8     = {{(`CPU_WIDTH-8){1'b0}}, ir.ra, ir.rb};
   assign alu_op   = ir.op;

   always_comb begin
      state_nxt = state;
      case (state)
         cpu_pkg::ST_FETCH:  state_nxt = cpu_pkg::ST_DECODE;
         cpu_pkg::ST_DECODE: state_nxt = cpu_pkg::ST_EXEC;
         cpu_pkg::ST_EXEC: begin
            if (is_load) begin
               state_nxt = cpu_pkg::ST_WB;
            end else if (ir.op == cpu_pkg::OP_HALT) begin
               state_nxt = cpu_pkg::ST_HALTED;
            end else begin
               state_nxt = cpu_pkg::ST_FETCH;
            end
         end
         cpu_pkg::ST_WB:     state_nxt = cpu_pkg::ST_FETCH;
         default:            state_nxt = cpu_pkg::ST_HALTED;
      endcase
   end

   // ##########################################################################
   // Register file command
   // ##########################################################################

   always_comb begin
      cmd          = '0;
      cmd.sel_a    = ir.ra;
      cmd.sel_b    = ir.rb;
      cmd.sel_d    = ir.rd;
      cmd.wb_idx   = ir.rd;
      cmd.wb_data  = alu_result;
      cmd.chg_data = da + cpu_pkg::word_t'(1);  // Post-increment of ra.

      case (state)
         cpu_pkg::ST_DECODE: begin
            cmd.inc_pc = 1'b1;
         end
         cpu_pkg::ST_EXEC: begin
            if (is_alu) begin
               cmd.wb_en = 1'b1;
            end else if (ir.op == cpu_pkg::OP_LDI) begin
               cmd.wb_en   = 1'b1;
               cmd.wb_data = imm8;
            end else if ((ir.op == cpu_pkg::OP_JMP) || (ir.op == cpu_pkg::OP_CALL) ||
                         ((ir.op == cpu_pkg::OP_BZ) && bz_taken)) begin
               cmd.wb_en   = 1'b1;
               cmd.wb_idx  = cpu_pkg::reg_idx_t'(`CPU_PC_IDX);
               cmd.wb_data = da;                // Jump target.
               cmd.link    = (ir.op == cpu_pkg::OP_CALL);
            end
         end
         cpu_pkg::ST_WB: begin
            cmd.wb_en   = 1'b1;
            cmd.wb_data = mem_rdata;
            cmd.chg_en  = (ir.op == cpu_pkg::OP_LDP);
         end
         default: begin
         end
      endcase
   end

   // ##########################################################################
   // Memory bus
   // ##########################################################################

   assign mem_addr  = (state == cpu_pkg::ST_EXEC) ? da : pc;
   assign mem_wdata = dd;
   assign mem_rd    = ((state == cpu_pkg::ST_FETCH) && running) ||
                      ((state == cpu_pkg::ST_EXEC) && is_load);
   assign mem_wr    = (state == cpu_pkg::ST_EXEC) && (ir.op == cpu_pkg::OP_ST);
   assign halted    = (state == cpu_pkg::ST_HALTED);

endmodule

`default_nettype wire

// File: design/reg_file.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module reg_file (
   input  wire                   clk,
   input  wire                   arst_n,
   input  wire cpu_pkg::rf_cmd_t cmd,
   output cpu_pkg::word_t        da,
   output cpu_pkg::word_t        db,
   output cpu_pkg::word_t        dd,
   output cpu_pkg::word_t        pc
);

   cpu_pkg::word_t        regs [`CPU_NREGS];
   cpu_pkg::word_t        p1_data [`CPU_NREGS];
   logic [`CPU_NREGS-1:0] p1_en;
   logic [`CPU_NREGS-1:0] p2_en;

   // ##########################################################################
   // Write port decode
   // ##########################################################################

   always_comb begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
         p1_en[i]   = cmd.wb_en && (cmd.wb_idx == cpu_pkg::reg_idx_t'(i));
         p1_data[i] = cmd.wb_data;
         p2_en[i]   = cmd.chg_en && (cmd.sel_a == cpu_pkg::reg_idx_t'(i));
      end

      // Link and increment override an ordinary port 1 write.
      if (cmd.link) begin
         p1_en[`CPU_LINK_IDX]   = 1'b1;
         p1_data[`CPU_LINK_IDX] = regs[`CPU_PC_IDX];
      end
      if (cmd.inc_pc) begin
         p1_en[`CPU_PC_IDX]   = 1'b1;
         p1_data[`CPU_PC_IDX] = regs[`CPU_PC_IDX] + cpu_pkg::word_t'(1);
      end
   end

   // ##########################################################################
   // Register array
   // ##########################################################################

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            regs[i] <= '0;
         end
         regs[`CPU_PC_IDX] <= `CPU_RESET_PC;
      end else begin
         for (int i = 0; i < `CPU_NREGS; i++) begin
            if (p1_en[i]) begin
               regs[i] <= p1_data[i];            // Port 1 wins.
            end else if (p2_en[i]) begin
               regs[i] <= cmd.chg_data;
            end
         end
      end
   end

   // ##########################################################################
   // Read ports
   // ##########################################################################

   assign da = regs[cmd.sel_a];
   assign db = regs[cmd.sel_b];
   assign dd = regs[cmd.sel_d];
   assign pc = regs[`CPU_PC_IDX];

endmodule

`default_nettype wire

// File: verification/cpu_core_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_core_tb;

   typedef struct packed {
      logic [3:0]     test;
      cpu_pkg::word_t addr;
      cpu_pkg::word_t data;
   } store_t;

   typedef struct packed {
      logic           rd;
      logic           wr;
      cpu_pkg::word_t addr;
      cpu_pkg::word_t wdata;
   } bus_t;

   localparam int NTESTS  = 6;
   localparam int SCRATCH = 13;                 // Holds store addresses.

   logic           clk;
   logic           arst_n;
   cpu_pkg::word_t mem_rdata;
   cpu_pkg::word_t mem_addr;
   cpu_pkg::word_t mem_wdata;
   logic           mem_rd;
   logic           mem_wr;
   logic           halted;

   cpu_pkg::word_t mem [256];
   bus_t           bus_q;
   store_t         exp_q [$];
   cpu_pkg::word_t skip_addrs [$];
   string          test_names [NTESTS] = '{"reset", "alu", "loads", "branches", "call", "halt"};
   int             errs [NTESTS];
   int             checks [NTESTS];
   bit             reported [NTESTS];
   int             bus_errs;
   int             pc_b;
   int             n_instr;
   int             cycles;
   int             limit;
   logic [31:0]    rng;

   cpu_core i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .mem_rdata (mem_rdata),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_rd    (mem_rd),
      .mem_wr    (mem_wr),
      .halted    (halted)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ##########################################################################
   // Reference rules and program builder
   // ##########################################################################

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng;
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      rng = x;
      return x;
   endfunction

   function automatic cpu_pkg::word_t alu_model(cpu_pkg::opcode_e op, cpu_pkg::word_t a,
                                                cpu_pkg::word_t b);
      case (op)
         cpu_pkg::OP_ADD: return a + b;
         cpu_pkg::OP_SUB: return a - b;
         cpu_pkg::OP_AND: return a & b;
         cpu_pkg::OP_OR:  return a | b;
         cpu_pkg::OP_XOR: return a ^ b;
         cpu_pkg::OP_SHL: return a << b[3:0];
         cpu_pkg::OP_SHR: return a >> b[3:0];
         default:         return a;
      endcase
   endfunction

   task automatic emit(cpu_pkg::opcode_e op, int rd, int ra, int rb);
      mem[pc_b] = {op, 4'(rd), 4'(ra), 4'(rb)};
      pc_b++;
      n_instr++;
   endtask

   task automatic emit_ldi(int rd, int imm);
      emit(cpu_pkg::OP_LDI, rd, (imm >> 4) & 15, imm & 15);
   endtask

   task automatic emit_store(int src, int addr, int test, cpu_pkg::word_t data);
      store_t e;
      emit_ldi(SCRATCH, addr);
      emit(cpu_pkg::OP_ST, src, SCRATCH, 0);
      e.test = 4'(test);
      e.addr = cpu_pkg::word_t'(addr);
      e.data = data;
      exp_q.push_back(e);
   endtask

   task automatic emit_skipped_store(int src, int addr);
      emit_ldi(SCRATCH, addr);
      emit(cpu_pkg::OP_ST, src, SCRATCH, 0);
      skip_addrs.push_back(cpu_pkg::word_t'(addr));
   endtask

   task automatic build_program();
      cpu_pkg::opcode_e alu_ops [7];
      cpu_pkg::word_t   a;
      cpu_pkg::word_t   b;
      cpu_pkg::word_t   t0;
      cpu_pkg::word_t   t1;
      cpu_pkg::word_t   t2;
      int               marker;
      int               call_addr;
      alu_ops = '{cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND, cpu_pkg::OP_OR,
                  cpu_pkg::OP_XOR, cpu_pkg::OP_SHL, cpu_pkg::OP_SHR};
      for (int i = 0; i < 256; i++) begin
         mem[i] = 16'he000 | 16'(i);             // HALT tagged with its address.
      end
      pc_b    = 0;
      n_instr = 0;

      foreach (alu_ops[k]) begin
         a = 16'(next_rand() & 32'hff);
         b = 16'(next_rand() & 32'hff);
         emit_ldi(1, a);
         emit_ldi(2, b);
         emit(alu_ops[k], 3, 1, 2);
         emit_store(3, 'hc0 + k, 1, alu_model(alu_ops[k], a, b));
      end

      t0 = 16'(next_rand());
      t1 = 16'(next_rand());
      t2 = 16'(next_rand());
      if (t2 == 16'h00a3) begin
         t2 = 16'h5a5a;                         // Must differ from ra+1.
      end
      mem['ha0] = t0;
      mem['ha1] = t1;
      mem['ha2] = t2;
      emit_ldi(4, 'ha0);
      emit(cpu_pkg::OP_LDP, 5, 4, 0);
      emit(cpu_pkg::OP_LDP, 6, 4, 0);
      emit(cpu_pkg::OP_ADD, 7, 5, 6);
      emit_store(7, 'hd0, 2, t0 + t1);
      emit_store(4, 'hd1, 2, 16'h00a2);
      emit(cpu_pkg::OP_LD, 9, 4, 0);
      emit_store(9, 'hd2, 2, t2);
      emit_ldi(8, 'ha2);
      emit(cpu_pkg::OP_LDP, 8, 8, 0);
      emit_store(8, 'hd3, 2, t2);               // Loaded word beats ra+1.

      marker = int'(next_rand() & 32'hff) | 1;
      emit_ldi(11, 0);
      emit_ldi(10, 'h60);
      emit(cpu_pkg::OP_BZ, 11, 10, 0);
      emit_skipped_store(11, 'he0);
      pc_b = 'h60;
      emit_ldi(12, marker);
      emit_store(12, 'he1, 3, 16'(marker));
      emit_ldi(10, 'h70);
      emit(cpu_pkg::OP_BZ, 12, 10, 0);          // Nonzero, falls through.
      emit_store(12, 'he2, 3, 16'(marker));
      emit_ldi(10, 'h78);
      emit(cpu_pkg::OP_JMP, 0, 10, 0);
      emit_skipped_store(12, 'he3);
      pc_b = 'h70;
      emit_skipped_store(12, 'he4);

      pc_b = 'h78;
      emit_ldi(10, 'h90);
      call_addr = pc_b;
      emit(cpu_pkg::OP_CALL, 0, 10, 0);
      pc_b = 'h90;
      emit_store(14, 'he5, 4, 16'(call_addr + 1));
      emit(cpu_pkg::OP_JMP, 0, 14, 0);
      pc_b = call_addr + 1;
      emit_store(12, 'he6, 4, 16'(marker));
      emit(cpu_pkg::OP_HALT, 0, 0, 0);
   endtask

   task automatic report_test(int t);
      reported[t] = 1'b1;
      $display("test %-8s %s  checks %0d  errors %0d", test_names[t],
               (errs[t] == 0) ? "passed" : "failed", checks[t], errs[t]);
   endtask

   // ##########################################################################
   // Memory model and bus checks
   // ##########################################################################

   always begin
      @(negedge clk);
      bus_q = {mem_rd, mem_wr, mem_addr, mem_wdata};
      @(posedge clk);
      #2;
      if (bus_q.wr) begin
         mem[bus_q.addr[7:0]] = bus_q.wdata;
      end
      if (bus_q.rd) begin
         mem_rdata = mem[bus_q.addr[7:0]];
      end
   end

   task automatic check_store();
      store_t e;
      if (exp_q.size() == 0) begin
         $display("unexpected store at %0t to address %h", $time, mem_addr);
         bus_errs++;
      end else begin
         e = exp_q.pop_front();
         checks[e.test] += 2;
         assert (mem_addr == e.addr) else begin
            $display("MISMATCH at %0t: mem_addr got %h expected %h", $time, mem_addr, e.addr);
            errs[e.test]++;
         end
         assert (mem_wdata == e.data) else begin
            $display("MISMATCH at %0t: mem_wdata got %h expected %h", $time, mem_wdata, e.data);
            errs[e.test]++;
         end
         if ((exp_q.size() == 0) || (exp_q[0].test != e.test)) begin
            report_test(e.test);
         end
      end
      foreach (skip_addrs[i]) begin
         assert (mem_addr != skip_addrs[i]) else begin
            $display("store from a skipped path reached address %h at %0t", mem_addr, $time);
            errs[3]++;
         end
      end
   endtask

   always @(negedge clk) begin
      if (arst_n && mem_wr) begin
         check_store();
      end
   end

   assert property (@(posedge clk) disable iff (!arst_n) !(mem_rd && mem_wr))
      else begin
         $display("read and write strobes high together at %0t", $time);
         bus_errs++;
      end

   assert property (@(posedge clk) disable iff (!arst_n)
                    halted |=> (halted && !mem_rd && !mem_wr))
      else begin
         $display("core left the halted state or raised a strobe at %0t", $time);
         errs[5]++;
      end

   // ##########################################################################
   // Sequence and timeout
   // ##########################################################################

   initial begin
      cycles = 0;
      @(posedge clk);
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: core did not halt within %0d cycles", cycles);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      int total;
      int failed;
      int nchecks;
      arst_n    = 1'b0;
      mem_rdata = '0;
      rng       = 32'd24374;
      bus_errs  = 0;
      build_program();
      limit = 4 * n_instr * 4 + 100;            // Loads take four cycles.

      repeat (10) begin
         @(negedge clk);
         checks[0]++;
         assert (!mem_rd && !mem_wr) else begin
            $display("memory strobe active during reset at %0t", $time);
            errs[0]++;
         end
      end
      @(posedge clk);
      #2;
      arst_n = 1'b1;
      @(negedge clk);
      checks[0]++;
      assert (!mem_rd && !mem_wr) else begin
         $display("memory strobe active in the first cycle after reset at %0t", $time);
         errs[0]++;
      end
      while (!mem_rd) begin
         @(negedge clk);
      end
      checks[0] += 2;
      assert (mem_addr == `CPU_RESET_PC) else begin
         $display("MISMATCH at %0t: mem_addr got %h expected %h", $time, mem_addr,
                  `CPU_RESET_PC);
         errs[0]++;
      end
      assert (!halted) else begin
         $display("MISMATCH at %0t: halted got %b expected 0", $time, halted);
         errs[0]++;
      end
      report_test(0);

      while (!halted) begin
         @(negedge clk);
      end
      repeat (20) begin
         @(negedge clk);
         checks[5]++;
         assert (halted && !mem_rd && !mem_wr) else begin
            $display("bus activity or halted low after HALT at %0t", $time);
            errs[5]++;
         end
      end
      while (exp_q.size() != 0) begin
         $display("expected store to address %h never happened", exp_q[0].addr);
         errs[exp_q[0].test]++;
         void'(exp_q.pop_front());
      end
      for (int t = 1; t < NTESTS; t++) begin
         if (!reported[t]) begin
            report_test(t);
         end
      end

      total   = bus_errs;
      failed  = 0;
      nchecks = 0;
      for (int t = 0; t < NTESTS; t++) begin
         total   += errs[t];
         nchecks += checks[t];
         if (errs[t] != 0) begin
            failed++;
         end
      end
      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors", NTESTS, failed,
               nchecks, total);
      if (total == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
